//--- imuldiv_defs.svh
/*
 * width and iteration constants for the multiply/divide unit
 * include this wherever a width or a count is needed
 */

`ifndef IMULDIV_DEFS_SVH
`define IMULDIV_DEFS_SVH

// operand width in bits
`define MULDIV_XLEN 32
// one shift step per operand bit
`define MULDIV_ITERS 32
// wide enough to hold MULDIV_ITERS - 1
`define MULDIV_CNT_W 5

`endif

//--- imuldiv_pkg.sv
/*
 * shared types for the multiply/divide unit
 * referenced by scoped name, never imported
 */

`include "imuldiv_defs.svh"

package imuldiv_pkg;

  // one signed operand word
  typedef logic signed [`MULDIV_XLEN-1:0] operand_t;

  // response word holds the product or {remainder, quotient}
  typedef logic [2*`MULDIV_XLEN-1:0] result_t;

  // function code carried with each request
  typedef enum logic {
    fn_mul = 1'b0,
    fn_div = 1'b1
  } muldiv_fn_t;

  // controller states
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } ctrl_state_t;

endpackage

//--- iter_counter.sv
/*
 * iteration down-counter for the 32-step operations
 * last is high during the final step
 */

`timescale 1ns/1ps

`include "imuldiv_defs.svh"

module iter_counter (
  input  logic clk,
  input  logic reset,
  input  logic load,
  input  logic step,
  output logic last
);

  localparam int unsigned cnt_w = `MULDIV_CNT_W;
  localparam logic [cnt_w-1:0] last_idx = cnt_w'(`MULDIV_ITERS - 1);

  logic [cnt_w-1:0] count;

  // load wins over step; a step at zero wraps back to last_idx
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= last_idx;
    end else if (load) begin
      count <= last_idx;
    end else if (step) begin
      count <= count - 1'b1;
    end
  end

  assign last = (count == '0);

  // once the final step is taken no further step comes before a reload
  a_no_overrun: assert property (@(posedge clk) disable iff (reset)
    (step && last && !load) |=> (!step || load));

endmodule

//--- mul_dpath.sv
/*
 * shift-and-add signed multiply datapath
 * works on magnitudes and fixes the sign on the way out
 */

`timescale 1ns/1ps

`include "imuldiv_defs.svh"

module mul_dpath (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   load,
  input  logic                   step,
  input  imuldiv_pkg::operand_t  a,
  input  imuldiv_pkg::operand_t  b,
  output imuldiv_pkg::result_t   result
);

  localparam int unsigned xlen = `MULDIV_XLEN;

  logic [xlen-1:0]   a_mag;
  logic [xlen-1:0]   b_mag;
  logic [2*xlen-1:0] a_q;
  logic [xlen-1:0]   b_q;
  logic [2*xlen-1:0] acc_q;
  logic              neg_q;

  // two's complement magnitudes; most negative maps to 2**31 unsigned
  assign a_mag = a[xlen-1] ? (~a + 1'b1) : a;
  assign b_mag = b[xlen-1] ? (~b + 1'b1) : b;

  // operand registers ------------------
  always_ff @(posedge clk) begin
    if (load) begin
      a_q   <= {{xlen{1'b0}}, a_mag};
      b_q   <= b_mag;
      acc_q <= '0;
    end else if (step) begin
      // add the shifted multiplicand when the current multiplier bit is set
      if (b_q[0]) acc_q <= acc_q + a_q;
      a_q <= a_q << 1;
      b_q <= b_q >> 1;
    end
  end

  // product sign
  always_ff @(posedge clk) begin
    if (reset) begin
      neg_q <= 1'b0;
    end else if (load) begin
      neg_q <= a[xlen-1] ^ b[xlen-1];
    end
  end

  // sign correction ------------------
  assign result = neg_q ? (~acc_q + 1'b1) : acc_q;

endmodule

//--- div_dpath.sv
/*
 * restoring signed divide datapath
 * result is {remainder, quotient} with sign and zero-divisor rules applied
 */

`timescale 1ns/1ps

`include "imuldiv_defs.svh"

module div_dpath (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   load,
  input  logic                   step,
  input  imuldiv_pkg::operand_t  a,
  input  imuldiv_pkg::operand_t  b,
  output imuldiv_pkg::result_t   result
);

  localparam int unsigned xlen = `MULDIV_XLEN;

  logic [xlen-1:0] a_mag;
  logic [xlen-1:0] b_mag;
  logic [xlen-1:0] quo_q;
  logic [xlen-1:0] rem_q;
  logic [xlen-1:0] dvs_q;
  logic            qneg_q;
  logic            rneg_q;
  logic            zero_q;

  logic [xlen:0]   shifted;
  logic [xlen+1:0] diff;
  logic            fits;
  logic [xlen-1:0] rem_fix;
  logic [xlen-1:0] quo_fix;

  assign a_mag = a[xlen-1] ? (~a + 1'b1) : a;
  assign b_mag = b[xlen-1] ? (~b + 1'b1) : b;

  // one restoring step ------------------
  // bring down the next dividend bit, subtract if the divisor fits
  assign shifted = {rem_q, quo_q[xlen-1]};
  assign diff    = {1'b0, shifted} - {2'b00, dvs_q};
  assign fits    = ~diff[xlen+1];

  // quo_q starts as the dividend and fills with quotient bits from the right
  always_ff @(posedge clk) begin
    if (load) begin
      quo_q <= a_mag;
      rem_q <= '0;
      dvs_q <= b_mag;
    end else if (step) begin
      quo_q <= {quo_q[xlen-2:0], fits};
      rem_q <= fits ? diff[xlen-1:0] : shifted[xlen-1:0];
    end
  end

  // sign and zero-divisor flags
  always_ff @(posedge clk) begin
    if (reset) begin
      qneg_q <= 1'b0;
      rneg_q <= 1'b0;
      zero_q <= 1'b0;
    end else if (load) begin
      qneg_q <= a[xlen-1] ^ b[xlen-1];
      rneg_q <= a[xlen-1];
      zero_q <= (b == '0);
    end
  end

  // sign correction ------------------
  // zero divisor always fits, so the raw quotient is all ones
  // and the remainder collects the dividend magnitude
  assign quo_fix = (qneg_q && !zero_q) ? (~quo_q + 1'b1) : quo_q;
  // remainder follows the dividend sign
  assign rem_fix = rneg_q ? (~rem_q + 1'b1) : rem_q;

  // min / -1 keeps a positive sign and its magnitude 2**31 already reads as min
  assign result = {rem_fix, quo_fix};

endmodule

//--- imuldiv_ctrl.sv
/*
 * FSM for the iterative multiply/divide unit
 * owns the valid/ready handshake and steers one datapath per request
 */

`timescale 1ns/1ps

module imuldiv_ctrl (
  input  logic                     clk,
  input  logic                     reset,
  input  imuldiv_pkg::muldiv_fn_t  req_fn,
  input  logic                     req_val,
  output logic                     req_rdy,
  output logic                     resp_val,
  input  logic                     resp_rdy,
  output imuldiv_pkg::result_t     resp_msg,
  output logic                     mul_load,
  output logic                     mul_step,
  output logic                     div_load,
  output logic                     div_step,
  output logic                     cnt_load,
  output logic                     cnt_step,
  input  logic                     cnt_last,
  input  imuldiv_pkg::result_t     mul_result,
  input  imuldiv_pkg::result_t     div_result
);

  imuldiv_pkg::ctrl_state_t state;
  imuldiv_pkg::ctrl_state_t state_next;
  imuldiv_pkg::muldiv_fn_t  fn_q;

  logic req_go;
  logic resp_go;
  logic in_calc;

  // handshake ------------------
  assign req_rdy  = (state == imuldiv_pkg::st_idle);
  assign resp_val = (state == imuldiv_pkg::st_done);
  assign req_go   = req_val && req_rdy;
  assign resp_go  = resp_val && resp_rdy;
  assign in_calc  = (state == imuldiv_pkg::st_calc);

  // next state
  always_comb begin
    state_next = state;
    case (state)
      imuldiv_pkg::st_idle: if (req_go) state_next = imuldiv_pkg::st_calc;
      // step taken with cnt_last high is the final one
      imuldiv_pkg::st_calc: if (cnt_last) state_next = imuldiv_pkg::st_done;
      imuldiv_pkg::st_done: if (resp_go) state_next = imuldiv_pkg::st_idle;
      default: state_next = imuldiv_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_pkg::st_idle;
      fn_q  <= imuldiv_pkg::fn_mul;
    end else begin
      state <= state_next;
      // function code held for the whole operation
      if (req_go) fn_q <= req_fn;
    end
  end

  // datapath steering ------------------
  // load uses the incoming code since fn_q updates on the same edge
  assign mul_load = req_go && (req_fn == imuldiv_pkg::fn_mul);
  assign div_load = req_go && (req_fn == imuldiv_pkg::fn_div);
  assign mul_step = in_calc && (fn_q == imuldiv_pkg::fn_mul);
  assign div_step = in_calc && (fn_q == imuldiv_pkg::fn_div);

  // counter loads on accept and steps alongside the datapath
  assign cnt_load = req_go;
  assign cnt_step = in_calc;

  // response word comes from whichever unit did the work
  assign resp_msg = (fn_q == imuldiv_pkg::fn_div) ? div_result : mul_result;

  // checks ------------------
  // datapath registers must hold under back-pressure
  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_msg)));

  // counter wraps off zero after the last step, so idle never sees it
  a_idle_not_last: assert property (@(posedge clk) disable iff (reset)
    (state == imuldiv_pkg::st_idle) |-> !cnt_last);

endmodule

//--- imuldiv.sv
/*
 * top of the iterative multiply/divide unit
 * one request in flight with a valid/ready handshake on both sides
 */

`timescale 1ns/1ps

module imuldiv (
  input  logic                     clk,
  input  logic                     reset,
  input  imuldiv_pkg::operand_t    req_a,
  input  imuldiv_pkg::operand_t    req_b,
  input  imuldiv_pkg::muldiv_fn_t  req_fn,
  input  logic                     req_val,
  output logic                     req_rdy,
  output imuldiv_pkg::result_t     resp_msg,
  output logic                     resp_val,
  input  logic                     resp_rdy
);

  // controller to datapath strobes
  logic mul_load;
  logic mul_step;
  logic div_load;
  logic div_step;

  // iteration counter
  logic cnt_load;
  logic cnt_step;
  logic cnt_last;

  // datapath results back to the controller
  imuldiv_pkg::result_t mul_result;
  imuldiv_pkg::result_t div_result;

  imuldiv_ctrl u_ctrl (
    .clk        (clk),
    .reset      (reset),
    .req_fn     (req_fn),
    .req_val    (req_val),
    .req_rdy    (req_rdy),
    .resp_val   (resp_val),
    .resp_rdy   (resp_rdy),
    .resp_msg   (resp_msg),
    .mul_load   (mul_load),
    .mul_step   (mul_step),
    .div_load   (div_load),
    .div_step   (div_step),
    .cnt_load   (cnt_load),
    .cnt_step   (cnt_step),
    .cnt_last   (cnt_last),
    .mul_result (mul_result),
    .div_result (div_result)
  );

  iter_counter u_counter (
    .clk   (clk),
    .reset (reset),
    .load  (cnt_load),
    .step  (cnt_step),
    .last  (cnt_last)
  );

  // both datapaths see the request operands; only the steered one loads
  mul_dpath u_mul (
    .clk    (clk),
    .reset  (reset),
    .load   (mul_load),
    .step   (mul_step),
    .a      (req_a),
    .b      (req_b),
    .result (mul_result)
  );

  div_dpath u_div (
    .clk    (clk),
    .reset  (reset),
    .load   (div_load),
    .step   (div_step),
    .a      (req_a),
    .b      (req_b),
    .result (div_result)
  );

endmodule

//--- imuldiv_tb_check.svh
/*
 * reference model and compare tasks for the multiply/divide testbench
 * included inside the testbench module
 */

`ifndef IMULDIV_TB_CHECK_SVH
`define IMULDIV_TB_CHECK_SVH

// most negative operand, the one value whose magnitude does not fit
localparam imuldiv_pkg::operand_t most_neg = {1'b1, {(`MULDIV_XLEN-1){1'b0}}};

// end of run on any error
task automatic stop_with_fail(input string why);
  $display("%s", why);
  $display("STATUS: FAIL");
  $fatal(1, "simulation stopped at the first error");
endtask

// expected response word ------------------
// 64-bit signed arithmetic, division truncates toward zero
function automatic imuldiv_pkg::result_t model_result(
  input imuldiv_pkg::operand_t   a,
  input imuldiv_pkg::operand_t   b,
  input imuldiv_pkg::muldiv_fn_t fn
);
  longint sa;
  longint sb;
  longint q;
  longint r;
  sa = longint'(a);
  sb = longint'(b);
  if (fn == imuldiv_pkg::fn_mul) begin
    return sa * sb;
  end
  if (sb == 64'sd0) begin
    // quotient all ones, remainder is the dividend
    q = -64'sd1;
    r = sa;
  end else if (a == most_neg && sb == -64'sd1) begin
    // overflow wraps back to the most negative number
    q = sa;
    r = 64'sd0;
  end else begin
    q = sa / sb;
    // remainder keeps the dividend sign
    r = sa % sb;
  end
  return {r[`MULDIV_XLEN-1:0], q[`MULDIV_XLEN-1:0]};
endfunction

// compare tasks ------------------
task automatic check_result(input imuldiv_pkg::result_t got, input imuldiv_pkg::result_t exp);
  if (got !== exp) begin
    stop_with_fail($sformatf("FAIL at time %0t: resp_msg is %h, expected %h",
                             $time, got, exp));
  end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    stop_with_fail($sformatf("FAIL at time %0t: %s is %b, expected %b",
                             $time, name, got, exp));
  end
endtask

`endif

//--- imuldiv_tb.sv
/*
 * testbench for the multiply/divide unit
 * random requests from a fixed seed, checked against a reference model
 */

`timescale 1ns/1ps

`include "imuldiv_defs.svh"

module imuldiv_tb;

  localparam int clk_period = 100;
  localparam int n_req      = 400;
  // the last requests keep req_val high with no gaps
  localparam int n_b2b      = 100;
  // accept edge to the edge where resp_val is first seen high
  localparam int resp_edges = 33;
  // watchdog budget per request, in cycles
  localparam int slack      = 45;

  logic                    clk;
  logic                    reset;
  imuldiv_pkg::operand_t   req_a;
  imuldiv_pkg::operand_t   req_b;
  imuldiv_pkg::muldiv_fn_t req_fn;
  logic                    req_val;
  logic                    req_rdy;
  imuldiv_pkg::result_t    resp_msg;
  logic                    resp_val;
  logic                    resp_rdy;

  integer               seed;
  int                   accepted;
  int                   returned;
  imuldiv_pkg::result_t expect_q[$];

  `include "imuldiv_tb_check.svh"

  imuldiv u_imuldiv (
    .clk      (clk),
    .reset    (reset),
    .req_a    (req_a),
    .req_b    (req_b),
    .req_fn   (req_fn),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_msg (resp_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  always #(clk_period / 2) clk = ~clk;

  // count the transfers the DUT actually makes on each side
  always @(posedge clk) begin
    if (!reset) begin
      if (req_val && req_rdy) begin
        accepted++;
      end
      if (resp_val && resp_rdy) begin
        returned++;
      end
    end
  end

  // corner values show up often, the rest is plain random
  function automatic imuldiv_pkg::operand_t pick_operand();
    logic [31:0] sel;
    sel = $random(seed);
    case (sel[2:0])
      3'd0: return '0;
      3'd1: return '1;
      3'd2: return most_neg;
      default: return $random(seed);
    endcase
  endfunction

  // one request through accept, calc, back-pressure and transfer ------------------
  // outputs are sampled at each rising edge, before the DUT registers update
  task automatic run_request(input bit back_to_back);
    imuldiv_pkg::operand_t   a;
    imuldiv_pkg::operand_t   b;
    imuldiv_pkg::muldiv_fn_t fn;
    imuldiv_pkg::result_t    exp;
    logic [31:0]             rnd;
    int                      hold;
    int                      edges;
    a    = pick_operand();
    b    = pick_operand();
    rnd  = $random(seed);
    fn   = imuldiv_pkg::muldiv_fn_t'(rnd[0]);
    hold = int'(rnd[10:8]) % 6;
    // idle gap, unit stays ready and quiet
    if (!back_to_back) begin
      req_val <= 1'b0;
      repeat (rnd[5:4]) begin
        @(posedge clk);
        check_flag("req_rdy", req_rdy, 1'b1);
        check_flag("resp_val", resp_val, 1'b0);
      end
    end
    req_a    <= a;
    req_b    <= b;
    req_fn   <= fn;
    req_val  <= 1'b1;
    resp_rdy <= (hold == 0);
    @(posedge clk);
    // accept edge
    check_flag("req_rdy", req_rdy, 1'b1);
    check_flag("resp_val", resp_val, 1'b0);
    expect_q.push_back(model_result(a, b, fn));
    if (!back_to_back) begin
      // junk on the operand bus must not reach the datapaths
      req_val <= 1'b0;
      req_a   <= $random(seed);
      req_b   <= $random(seed);
    end
    edges = 0;
    do begin
      @(posedge clk);
      edges++;
      check_flag("req_rdy", req_rdy, 1'b0);
    end while (!resp_val && edges < resp_edges + 4);
    if (edges != resp_edges) begin
      stop_with_fail($sformatf("resp_val seen %0d edges after accept, expected %0d",
                               edges, resp_edges));
    end
    exp = expect_q.pop_front();
    // back-pressure holds the response
    for (int k = 0; k < hold; k++) begin
      check_flag("resp_val", resp_val, 1'b1);
      check_flag("req_rdy", req_rdy, 1'b0);
      check_result(resp_msg, exp);
      if (k == hold - 1) begin
        resp_rdy <= 1'b1;
      end
      @(posedge clk);
    end
    // transfer edge
    check_flag("resp_val", resp_val, 1'b1);
    check_result(resp_msg, exp);
  endtask

  initial begin
    seed     = 32'hc63e;
    accepted = 0;
    returned = 0;
    clk      = 1'b0;
    reset    = 1'b1;
    req_a    = '0;
    req_b    = '0;
    req_fn   = imuldiv_pkg::fn_mul;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    check_flag("req_rdy", req_rdy, 1'b1);
    check_flag("resp_val", resp_val, 1'b0);
    for (int i = 0; i < n_req; i++) begin
      run_request(i >= n_req - n_b2b);
    end
    @(posedge clk);
    if (accepted == n_req && returned == n_req && expect_q.size() == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      stop_with_fail("request and response counts do not match");
    end
  end

  // watchdog sized from reset plus the per-request budget
  initial begin
    #((8 + n_req * slack) * clk_period);
    stop_with_fail("no response arrived in time");
  end

endmodule

//--- imuldiv.f
+incdir+.
imuldiv_pkg.sv
iter_counter.sv
mul_dpath.sv
div_dpath.sv
imuldiv_ctrl.sv
imuldiv.sv
imuldiv_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert
LINT_FLAGS := --lint-only --timing
TOP       := imuldiv_tb
RTL_TOP   := imuldiv
FILELIST  := imuldiv.f
OBJ_DIR   := obj_dir
PASS_MSG  := STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
